/* Bender.yml */
package:
  name: egr_slice

sources:
  - include_dirs:
      - .
    files:
      - egr_pkg.sv
      - egr_tag_queue.sv
      - egr_port_sched.sv
      - egr_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - egr_tb.sv

/* egr_consts.svh */
// Sizing macros shared by the egress slice RTL and its testbench
// Include wherever a port count, field width or queue depth is needed
`ifndef EGR_CONSTS_SVH
`define EGR_CONSTS_SVH

// ==================================================
// Port side
// ==================================================

// Ethernet transmit ports
`define EGR_NUM_PORTS 4

// ==================================================
// Tag fields
// ==================================================

// Full tag word
`define EGR_TAG_W 32

// Frame length in words, legal range 1 to 255
`define EGR_LEN_W 8

// Packet memory word address
`define EGR_ADDR_W 16

// ==================================================
// Queueing
// ==================================================

// Default entries per tag queue
`define EGR_TAG_DEPTH 4

`endif

/* egr_pkg.sv */
// Tag types for the egress slice
// Modules and the testbench pull these in with a wildcard import
`default_nettype none

`include "egr_consts.svh"

package egr_pkg;

  // One bit per transmit port
  typedef logic [`EGR_NUM_PORTS-1:0] port_mask_t;

  // ==================================================
  // Unicast view of a tag word
  // ==================================================
  typedef struct packed {
    // Always 0 in this view
    logic                                mc;
    // Single destination port
    logic [$clog2(`EGR_NUM_PORTS)-1:0]   dest;
    logic [4:0]                          rsvd;
    logic [`EGR_LEN_W-1:0]               len;
    logic [`EGR_ADDR_W-1:0]              start;
  } egr_uc_tag_t;

  // ==================================================
  // Multicast view of a tag word
  // ==================================================
  typedef struct packed {
    // Always 1 in this view
    logic                   mc;
    // Destination set
    port_mask_t             mask;
    logic [2:0]             rsvd;
    logic [`EGR_LEN_W-1:0]  len;
    logic [`EGR_ADDR_W-1:0] start;
  } egr_mc_tag_t;

  // Flag, length and start pointer line up in both views
  typedef union packed {
    egr_uc_tag_t uc;
    egr_mc_tag_t mc;
  } egr_tag_u;

endpackage

`default_nettype wire

/* egr_port_sched.sv */
// Egress port scheduler
// Picks between the two tag queue heads by round robin, expands each tag
// into one frame per destination port and emits one read address per beat
`timescale 1ns/1ps
`default_nettype none

`include "egr_consts.svh"

module egr_port_sched
  import egr_pkg::*;
(
  input  logic                   egress_clock,
  input  logic                   rst_n,
  input  logic                   head_valid_0,
  input  logic                   head_valid_1,
  input  egr_tag_u               head_tag_0,
  input  egr_tag_u               head_tag_1,
  output logic                   pop_0,
  output logic                   pop_1,
  input  port_mask_t             port_enable,
  output port_mask_t             tx_valid,
  output logic                   tx_sop,
  output logic                   tx_eop,
  output logic [`EGR_ADDR_W-1:0] tx_addr
);

  localparam int PORT_W = $clog2(`EGR_NUM_PORTS);

  // Lowest set bit of a port mask
  function automatic logic [PORT_W-1:0] lowest_port(input port_mask_t m);
    logic [PORT_W-1:0] idx;
    idx = '0;
    // Walk downward so the lowest hit wins
    for (int i = `EGR_NUM_PORTS - 1; i >= 0; i--) begin
      if (m[i]) begin
        idx = PORT_W'(i);
      end
    end
    return idx;
  endfunction

  // ==================================================
  // State
  // ==================================================

  // Ports still owed a frame for the active tag
  port_mask_t             rem_mask;
  logic [`EGR_LEN_W-1:0]  beat_idx;
  // Latched tag payload
  logic [`EGR_LEN_W-1:0]  len_q;
  logic [`EGR_ADDR_W-1:0] start_q;
  // High favours queue 1
  logic                   rr_ptr;

  logic                   busy;
  logic                   grant_0;
  logic                   grant_1;
  logic                   take;
  egr_tag_u               head_sel;
  port_mask_t             new_mask;
  logic [PORT_W-1:0]      cur_port;
  port_mask_t             cur_onehot;
  logic                   beat_fire;
  logic                   last_beat;

  // Idle once every port of the tag is served
  assign busy = |rem_mask;

  // ==================================================
  // Round-robin grant
  // ==================================================
  always_comb begin
    grant_0 = 1'b0;
    grant_1 = 1'b0;
    if (!busy) begin
      if (head_valid_0 && head_valid_1) begin
        grant_0 = ~rr_ptr;
        grant_1 = rr_ptr;
      end else begin
        // Lone head wins
        grant_0 = head_valid_0;
        grant_1 = head_valid_1;
      end
    end
  end

  assign take  = grant_0 | grant_1;
  assign pop_0 = grant_0;
  assign pop_1 = grant_1;

  // Granted head and its destination set
  assign head_sel = grant_1 ? head_tag_1 : head_tag_0;

  always_comb begin
    if (head_sel.uc.mc) begin
      new_mask = head_sel.mc.mask;
    end else begin
      new_mask = port_mask_t'(1) << head_sel.uc.dest;
    end
  end

  // ==================================================
  // Beat generation
  // ==================================================
  assign cur_port   = lowest_port(rem_mask);
  assign cur_onehot = port_mask_t'(1) << cur_port;

  // Disabled port stalls the beat in place
  assign beat_fire = busy & |(cur_onehot & port_enable);
  assign last_beat = (beat_idx == (len_q - `EGR_LEN_W'(1)));

  assign tx_valid = beat_fire ? cur_onehot : '0;
  assign tx_sop   = beat_fire & (beat_idx == '0);
  assign tx_eop   = beat_fire & last_beat;
  // Wraps at 16 bits
  assign tx_addr  = start_q + `EGR_ADDR_W'(beat_idx);

  // Control state
  always_ff @(posedge egress_clock or negedge rst_n) begin
    if (!rst_n) begin
      rem_mask <= '0;
      beat_idx <= '0;
      rr_ptr   <= 1'b0;
    end else if (take) begin
      rem_mask <= new_mask;
      beat_idx <= '0;
      // Other queue goes first next time
      rr_ptr   <= grant_0;
    end else if (beat_fire) begin
      if (last_beat) begin
        // Port done, move to the next mask bit
        rem_mask <= rem_mask & ~cur_onehot;
        beat_idx <= '0;
      end else begin
        beat_idx <= beat_idx + 1'b1;
      end
    end
  end

  // Tag payload
  always_ff @(posedge egress_clock) begin
    if (take) begin
      len_q   <= head_sel.uc.len;
      start_q <= head_sel.uc.start;
    end
  end

  // ==================================================
  // Checks
  // ==================================================
  a_tx_onehot: assert property (
    @(posedge egress_clock) disable iff (!rst_n)
    $onehot0(tx_valid)
  ) else $error("tx_valid names more than one port");

  a_mark_valid: assert property (
    @(posedge egress_clock) disable iff (!rst_n)
    (tx_sop || tx_eop) |-> |tx_valid
  ) else $error("sop or eop without a valid beat");

  a_pop_excl: assert property (
    @(posedge egress_clock) disable iff (!rst_n)
    !(pop_0 && pop_1)
  ) else $error("both queues popped together");

endmodule

`default_nettype wire

/* egr_tag_queue.sv */
// Tag FIFO for one tag stream of the egress slice
// Stores strobed tags and shows the oldest one to the scheduler
// A pop pulse advances the head on the following edge
`timescale 1ns/1ps
`default_nettype none

`include "egr_consts.svh"

module egr_tag_queue
  import egr_pkg::*;
#(
  parameter int DEPTH = `EGR_TAG_DEPTH
) (
  input  logic     egress_clock,
  input  logic     rst_n,
  input  logic     tag_valid,
  input  egr_tag_u tag,
  output logic     tag_full,
  input  logic     pop,
  output logic     head_valid,
  output egr_tag_u head_tag
);

  // ==================================================
  // Sizes
  // ==================================================

  // Pointers wrap on their own for power-of-two depths
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  if (DEPTH < 2 || (DEPTH & (DEPTH - 1)) != 0) begin : g_depth_check
    $error("egr_tag_queue needs a power-of-two DEPTH of at least 2");
  end

  // ==================================================
  // Storage and pointers
  // ==================================================
  logic [`EGR_TAG_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [CNT_W-1:0]      count;
  logic                  wr_en;
  logic                  rd_en;

  // Qualified write and read
  assign wr_en = tag_valid & ~tag_full;
  assign rd_en = pop & head_valid;

  // Status levels follow the entry count
  assign tag_full   = (count == CNT_W'(DEPTH));
  assign head_valid = (count != '0);

  // Oldest entry
  assign head_tag = mem[rd_ptr];

  // Tag payload
  always_ff @(posedge egress_clock) begin
    if (wr_en) begin
      mem[wr_ptr] <= tag;
    end
  end

  // Pointer and count update
  always_ff @(posedge egress_clock or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous write and pop keeps the count
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ==================================================
  // Checks on the source and the scheduler
  // ==================================================

  // Tag source must respect the full level
  a_no_write_full: assert property (
    @(posedge egress_clock) disable iff (!rst_n)
    tag_valid |-> !tag_full
  ) else $error("tag written while queue full");

  // Scheduler pops only a valid head
  a_no_pop_empty: assert property (
    @(posedge egress_clock) disable iff (!rst_n)
    pop |-> head_valid
  ) else $error("pop while queue empty");

  // Zero length would never end a frame
  a_len_nonzero: assert property (
    @(posedge egress_clock) disable iff (!rst_n)
    tag_valid |-> (tag.uc.len != '0)
  ) else $error("tag with zero length");

  // Multicast needs at least one port
  a_mask_nonzero: assert property (
    @(posedge egress_clock) disable iff (!rst_n)
    (tag_valid && tag.mc.mc) |-> (tag.mc.mask != '0)
  ) else $error("multicast tag with empty port mask");

endmodule

`default_nettype wire

/* egr_tb.sv */
// Self-checking testbench for the egress slice
// Drives both tag streams, models the expected beats cycle by cycle
// and checks the TX side and the full levels with concurrent assertions
`timescale 1ns/1ps
`default_nettype none

`include "egr_consts.svh"

module egr_tb
  import egr_pkg::*;
();

  localparam int PORT_W        = $clog2(`EGR_NUM_PORTS);
  localparam int CLK_PERIOD    = 4;
  localparam int DRIVE_DLY     = 1;
  localparam int RESET_CYCLES  = 4;
  localparam int TAGS_PER_TEST = 8;
  // Reset, gaps between tests and the deliberate stall
  localparam int SLACK_CYCLES  = 200;
  localparam logic [31:0] SEED = 32'he814;

  // One expected TX beat
  typedef struct packed {
    logic [PORT_W-1:0]      port;
    logic [`EGR_ADDR_W-1:0] addr;
    logic                   sop;
    logic                   eop;
  } beat_t;

  logic                   egress_clock;
  logic                   rst_n;
  logic                   tag_valid_0;
  egr_tag_u               tag_0;
  logic                   tag_full_0;
  logic                   tag_valid_1;
  egr_tag_u               tag_1;
  logic                   tag_full_1;
  port_mask_t             port_enable;
  port_mask_t             tx_valid;
  logic                   tx_sop;
  logic                   tx_eop;
  logic [`EGR_ADDR_W-1:0] tx_addr;

  // Reference model
  egr_tag_u   mq0[$];
  egr_tag_u   mq1[$];
  beat_t      exp_q[$];
  logic       rr_favour_1;
  logic       model_idle;
  logic       tags_seen;
  logic       exp_have;
  beat_t      exp_beat;
  logic       exp_full_0;
  logic       exp_full_1;
  port_mask_t exp_tx_valid;

  int   err_count;
  int   err_at_start;
  int   tests_passed;
  int   tests_failed;
  int   test_num;
  int   plan_beats;
  int   plan_tags;
  logic bp_active;

  egr_top dut_i (
    .egress_clock (egress_clock),
    .rst_n        (rst_n),
    .tag_valid_0  (tag_valid_0),
    .tag_0        (tag_0),
    .tag_full_0   (tag_full_0),
    .tag_valid_1  (tag_valid_1),
    .tag_1        (tag_1),
    .tag_full_1   (tag_full_1),
    .port_enable  (port_enable),
    .tx_valid     (tx_valid),
    .tx_sop       (tx_sop),
    .tx_eop       (tx_eop),
    .tx_addr      (tx_addr)
  );

  initial begin
    egress_clock = 1'b0;
    forever #(CLK_PERIOD / 2) egress_clock = ~egress_clock;
  end

  // ==================================================
  // Tag builders and drivers
  // ==================================================

  // Ports a tag goes to
  function automatic port_mask_t dest_mask(input egr_tag_u t);
    if (t.mc.mc) begin
      return t.mc.mask;
    end
    return port_mask_t'(1) << t.uc.dest;
  endfunction

  function automatic egr_tag_u uc_tag(input int dest, input int len,
                                      input logic [`EGR_ADDR_W-1:0] start);
    egr_tag_u t;
    t          = '0;
    t.uc.dest  = PORT_W'(dest);
    t.uc.len   = `EGR_LEN_W'(len);
    t.uc.start = start;
    return t;
  endfunction

  function automatic egr_tag_u mc_tag(input port_mask_t mask, input int len,
                                      input logic [`EGR_ADDR_W-1:0] start);
    egr_tag_u t;
    t          = '0;
    t.mc.mc    = 1'b1;
    t.mc.mask  = mask;
    t.mc.len   = `EGR_LEN_W'(len);
    t.mc.start = start;
    return t;
  endfunction

  // Half unicast, half multicast
  function automatic egr_tag_u random_tag(input int max_len);
    int                     len;
    logic [`EGR_ADDR_W-1:0] start;
    len   = $urandom_range(max_len, 1);
    start = `EGR_ADDR_W'($urandom);
    if ($urandom_range(1, 0) == 0) begin
      return uc_tag($urandom_range(`EGR_NUM_PORTS - 1, 0), len, start);
    end
    return mc_tag(port_mask_t'($urandom_range((1 << `EGR_NUM_PORTS) - 1, 1)), len, start);
  endfunction

  // Watchdog budget in ns
  function automatic longint watch_limit();
    return longint'(2 * (plan_beats + 2 * plan_tags) + SLACK_CYCLES) * CLK_PERIOD;
  endfunction

  task automatic next_cycle();
    @(posedge egress_clock);
    #DRIVE_DLY;
  endtask

  // One-cycle strobe, held off while the queue is full
  task automatic send_tag(input int stream, input egr_tag_u t);
    plan_tags++;
    plan_beats += $countones(dest_mask(t)) * int'(t.uc.len);
    if (stream == 0) begin
      while (tag_full_0) next_cycle();
      tag_valid_0 = 1'b1;
      tag_0       = t;
      next_cycle();
      tag_valid_0 = 1'b0;
    end else begin
      while (tag_full_1) next_cycle();
      tag_valid_1 = 1'b1;
      tag_1       = t;
      next_cycle();
      tag_valid_1 = 1'b0;
    end
  endtask

  task automatic send_random(input int stream, input int count, input int max_len);
    for (int i = 0; i < count; i++) begin
      send_tag(stream, random_tag(max_len));
    end
  endtask

  // Each port enabled about three cycles in four
  task automatic toggle_enables();
    while (bp_active) begin
      port_enable = port_mask_t'(~($urandom & $urandom));
      next_cycle();
    end
  endtask

  task automatic wait_drain();
    while (!model_idle) next_cycle();
    repeat (2) next_cycle();
  endtask

  task automatic finish_test(input string name);
    wait_drain();
    test_num++;
    if (err_count == err_at_start) begin
      tests_passed++;
      $display("test %0d %s: pass", test_num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: fail, %0d check errors", test_num, name, err_count - err_at_start);
    end
    err_at_start = err_count;
  endtask

  // ==================================================
  // Reference model
  // ==================================================

  // One frame per mask port, lowest port first
  task automatic expand_tag(input egr_tag_u t);
    port_mask_t m;
    beat_t      b;
    m = dest_mask(t);
    for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
      for (int i = 0; i < int'(t.uc.len) && m[p]; i++) begin
        b.port = PORT_W'(p);
        b.addr = t.uc.start + `EGR_ADDR_W'(i);
        b.sop  = (i == 0);
        b.eop  = (i == int'(t.uc.len) - 1);
        exp_q.push_back(b);
      end
    end
  endtask

  // Grant sees only tags written on earlier edges
  always @(posedge egress_clock or negedge rst_n) begin
    if (!rst_n) begin
      mq0.delete();
      mq1.delete();
      exp_q.delete();
      rr_favour_1 = 1'b0;
      tags_seen  <= 1'b0;
      model_idle <= 1'b1;
      exp_have   <= 1'b0;
      exp_beat   <= '0;
      exp_full_0 <= 1'b0;
      exp_full_1 <= 1'b0;
    end else begin
      if (exp_q.size() != 0) begin
        // Beat leaves only on an enabled port
        if (port_enable[exp_q[0].port]) begin
          void'(exp_q.pop_front());
        end
      end else if (mq0.size() != 0 && (mq1.size() == 0 || !rr_favour_1)) begin
        expand_tag(mq0.pop_front());
        rr_favour_1 = 1'b1;
      end else if (mq1.size() != 0) begin
        expand_tag(mq1.pop_front());
        rr_favour_1 = 1'b0;
      end
      if (tag_valid_0) begin
        mq0.push_back(tag_0);
      end
      if (tag_valid_1) begin
        mq1.push_back(tag_1);
      end
      if (tag_valid_0 || tag_valid_1) begin
        tags_seen <= 1'b1;
      end
      model_idle <= (exp_q.size() == 0) && (mq0.size() == 0) && (mq1.size() == 0);
      exp_have   <= (exp_q.size() != 0);
      exp_beat   <= (exp_q.size() != 0) ? exp_q[0] : '0;
      exp_full_0 <= (mq0.size() == `EGR_TAG_DEPTH);
      exp_full_1 <= (mq1.size() == `EGR_TAG_DEPTH);
    end
  end

  assign exp_tx_valid = (exp_have && port_enable[exp_beat.port]) ?
                        (port_mask_t'(1) << exp_beat.port) : '0;

  // ==================================================
  // Checks
  // ==================================================
  a_tx_valid: assert property (
    @(posedge egress_clock) disable iff (!rst_n) tx_valid == exp_tx_valid
  ) else begin
    err_count++;
    $display("CHECK FAILED tx_valid expected %h got %h", $sampled(exp_tx_valid),
             $sampled(tx_valid));
  end

  a_tx_addr: assert property (
    @(posedge egress_clock) disable iff (!rst_n) (|exp_tx_valid) |-> (tx_addr == exp_beat.addr)
  ) else begin
    err_count++;
    $display("CHECK FAILED tx_addr expected %h got %h", $sampled(exp_beat.addr),
             $sampled(tx_addr));
  end

  a_tx_sop: assert property (
    @(posedge egress_clock) disable iff (!rst_n) tx_sop == (|exp_tx_valid && exp_beat.sop)
  ) else begin
    err_count++;
    $display("CHECK FAILED tx_sop expected %h got %h",
             $sampled(|exp_tx_valid && exp_beat.sop), $sampled(tx_sop));
  end

  a_tx_eop: assert property (
    @(posedge egress_clock) disable iff (!rst_n) tx_eop == (|exp_tx_valid && exp_beat.eop)
  ) else begin
    err_count++;
    $display("CHECK FAILED tx_eop expected %h got %h",
             $sampled(|exp_tx_valid && exp_beat.eop), $sampled(tx_eop));
  end

  a_full_0: assert property (
    @(posedge egress_clock) disable iff (!rst_n) tag_full_0 == exp_full_0
  ) else begin
    err_count++;
    $display("CHECK FAILED tag_full_0 expected %h got %h", $sampled(exp_full_0),
             $sampled(tag_full_0));
  end

  a_full_1: assert property (
    @(posedge egress_clock) disable iff (!rst_n) tag_full_1 == exp_full_1
  ) else begin
    err_count++;
    $display("CHECK FAILED tag_full_1 expected %h got %h", $sampled(exp_full_1),
             $sampled(tag_full_1));
  end

  // Quiet outputs in and after reset until the first tag
  a_reset_quiet: assert property (
    @(posedge egress_clock) (!rst_n || !tags_seen) |->
      (tx_valid == '0 && !tx_sop && !tx_eop && !tag_full_0 && !tag_full_1)
  ) else begin
    err_count++;
    $display("CHECK FAILED tx_valid %h tx_sop %h tx_eop %h tag_full_0 %h tag_full_1 %h",
             $sampled(tx_valid), $sampled(tx_sop), $sampled(tx_eop),
             $sampled(tag_full_0), $sampled(tag_full_1));
  end

  // ==================================================
  // Watchdog and test sequence
  // ==================================================
  initial begin
    while ($time <= watch_limit()) @(posedge egress_clock);
    $display("watchdog: the tests did not finish within %0d ns", watch_limit());
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    void'($urandom(SEED));
    rst_n        = 1'b0;
    tag_valid_0  = 1'b0;
    tag_0        = '0;
    tag_valid_1  = 1'b0;
    tag_1        = '0;
    port_enable  = '1;
    bp_active    = 1'b0;
    err_count    = 0;
    err_at_start = 0;
    tests_passed = 0;
    tests_failed = 0;
    test_num     = 0;
    plan_beats   = 0;
    plan_tags    = 0;
    repeat (RESET_CYCLES) @(posedge egress_clock);
    #DRIVE_DLY;
    rst_n = 1'b1;
    repeat (4) next_cycle();
    finish_test("reset state");

    // Idle system before each directed tag
    send_tag(0, uc_tag(2, 3, 16'h0100));
    wait_drain();
    send_tag(1, uc_tag(0, 1, 16'h2000));
    wait_drain();
    // Address wraps past the top
    send_tag(0, uc_tag(3, 5, 16'hfffd));
    wait_drain();
    for (int i = 0; i < TAGS_PER_TEST; i++) begin
      send_tag(0, uc_tag($urandom_range(3, 0), $urandom_range(6, 1), `EGR_ADDR_W'($urandom)));
    end
    finish_test("unicast frames");

    send_tag(0, mc_tag(4'b1011, 4, 16'h0400));
    send_tag(1, mc_tag(4'b1111, 2, 16'h0800));
    send_tag(0, mc_tag(4'b0110, 3, 16'hfffe));
    for (int i = 0; i < TAGS_PER_TEST; i++) begin
      send_tag(i % 2, mc_tag(port_mask_t'($urandom_range(15, 1)), $urandom_range(5, 1),
                             `EGR_ADDR_W'($urandom)));
    end
    finish_test("multicast expansion");

    // Both queues loaded together
    fork
      send_random(0, TAGS_PER_TEST, 5);
      send_random(1, TAGS_PER_TEST, 5);
    join
    wait_drain();
    // Lone queue served back to back
    send_random(1, TAGS_PER_TEST / 2, 3);
    finish_test("round robin");

    bp_active = 1'b1;
    fork
      toggle_enables();
      begin
        fork
          send_random(0, TAGS_PER_TEST, 4);
          send_random(1, TAGS_PER_TEST, 4);
        join
        while (!model_idle) next_cycle();
        bp_active = 1'b0;
      end
    join
    port_enable = '1;
    finish_test("back-pressure");

    // First tag sits in the scheduler and four more fill the queue
    port_enable = 4'b0111;
    repeat (`EGR_TAG_DEPTH + 1) send_tag(0, uc_tag(3, $urandom_range(4, 1),
                                                   `EGR_ADDR_W'($urandom)));
    assert (tag_full_0) else begin
      err_count++;
      $display("CHECK FAILED tag_full_0 expected %h got %h", 1'b1, tag_full_0);
    end
    repeat (3) next_cycle();
    port_enable = '1;
    finish_test("queue full");

    $display("tests passed %0d failed %0d, check errors %0d", tests_passed, tests_failed,
             err_count);
    if (tests_failed == 0 && err_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* egr_top.sv */
// Top of the egress slice
// Two tag streams feed their own queue and one scheduler drives four TX ports
`timescale 1ns/1ps
`default_nettype none

`include "egr_consts.svh"

module egr_top
  import egr_pkg::*;
(
  input  logic                   egress_clock,
  input  logic                   rst_n,
  // Tag stream 0
  input  logic                   tag_valid_0,
  input  egr_tag_u               tag_0,
  output logic                   tag_full_0,
  // Tag stream 1
  input  logic                   tag_valid_1,
  input  egr_tag_u               tag_1,
  output logic                   tag_full_1,
  // Ethernet transmit side
  input  port_mask_t             port_enable,
  output port_mask_t             tx_valid,
  output logic                   tx_sop,
  output logic                   tx_eop,
  output logic [`EGR_ADDR_W-1:0] tx_addr
);

  // ==================================================
  // Queue to scheduler wires
  // ==================================================
  logic     head_valid_0;
  logic     head_valid_1;
  egr_tag_u head_tag_0;
  egr_tag_u head_tag_1;
  logic     pop_0;
  logic     pop_1;

  // Stream 0 queue
  egr_tag_queue queue_0_i (
    .egress_clock (egress_clock),
    .rst_n        (rst_n),
    .tag_valid    (tag_valid_0),
    .tag          (tag_0),
    .tag_full     (tag_full_0),
    .pop          (pop_0),
    .head_valid   (head_valid_0),
    .head_tag     (head_tag_0)
  );

  // Stream 1 queue
  egr_tag_queue queue_1_i (
    .egress_clock (egress_clock),
    .rst_n        (rst_n),
    .tag_valid    (tag_valid_1),
    .tag          (tag_1),
    .tag_full     (tag_full_1),
    .pop          (pop_1),
    .head_valid   (head_valid_1),
    .head_tag     (head_tag_1)
  );

  // Arbitration and frame expansion
  egr_port_sched sched_i (
    .egress_clock (egress_clock),
    .rst_n        (rst_n),
    .head_valid_0 (head_valid_0),
    .head_valid_1 (head_valid_1),
    .head_tag_0   (head_tag_0),
    .head_tag_1   (head_tag_1),
    .pop_0        (pop_0),
    .pop_1        (pop_1),
    .port_enable  (port_enable),
    .tx_valid     (tx_valid),
    .tx_sop       (tx_sop),
    .tx_eop       (tx_eop),
    .tx_addr      (tx_addr)
  );

endmodule

`default_nettype wire

/* sim.f */
+incdir+.
egr_pkg.sv
egr_tag_queue.sv
egr_port_sched.sv
egr_top.sv
egr_tb.sv
